/* design/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // bus and core word widths.
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // byte offset of an access within a bus word.
    localparam int OFFSET_BITS = 2;

    // one-hot access type fields mem_wtype and mem_rtype.
    localparam int SIZE_BITS = 3;
    localparam int SIZE_BYTE = 0;
    localparam int SIZE_HALF = 1;
    localparam int SIZE_WORD = 2;

    // extension fields, bit 0 is 8 bits and bit 1 is 16 bits.
    localparam int EXT_BITS = 2;
    localparam int EXT_8     = 0;
    localparam int EXT_16    = 1;

    // AXI side fields.
    localparam int PROT_BITS = 3;
    localparam int RESP_BITS = 2;

    localparam logic [PROT_BITS-1:0] PROT_NONE = 3'b000; // unprivileged, secure, data.
    localparam logic [RESP_BITS-1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

/* design/lsu_request.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_request
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_valid,
    input  logic                   mem_ren,
    input  logic                   mem_wen,
    input  logic [ADDR_WIDTH-1:0]  alu_result,
    input  logic [DATA_WIDTH-1:0]  mem_wdata,
    input  logic [SIZE_BITS-1:0]   mem_wtype,
    input  logic [SIZE_BITS-1:0]   mem_rtype,
    input  logic [EXT_BITS-1:0]    mem_zero_width,
    input  logic [EXT_BITS-1:0]    mem_sext_width,
    input  logic                   wr_busy,
    input  logic                   rd_busy,
    output logic                   mem_access_flag,
    output logic                   wr_start,
    output logic [ADDR_WIDTH-1:0]  wr_addr,
    output logic [DATA_WIDTH-1:0]  wr_data,
    output logic [STRB_WIDTH-1:0]  wr_strb,
    output logic                   rd_start,
    output logic [ADDR_WIDTH-1:0]  rd_addr,
    output logic [OFFSET_BITS-1:0] ld_offset,
    output logic [SIZE_BITS-1:0]   ld_size,
    output logic                   ld_sext
);

    logic                   wen_q;
    logic                   ren_q;
    logic                   wen_rise;
    logic                   ren_rise;
    logic [OFFSET_BITS-1:0] offset;
    logic                   st_word;
    logic                   st_half;
    logic                   st_byte;
    logic                   ld_raw;
    logic [SIZE_BITS-1:0]   ld_size_next;

    // previous enable levels for edge detection.
    always_ff @(posedge clk) begin
        if (rst) begin
            wen_q <= 1'b0;
            ren_q <= 1'b0;
        end else begin
            wen_q <= mem_wen;
            ren_q <= mem_ren;
        end
    end

    assign wen_rise = mem_valid & mem_wen & ~wen_q;
    assign ren_rise = mem_valid & mem_ren & ~ren_q;

    // an edge seen while the channel is busy is lost.
    assign wr_start = wen_rise & ~wr_busy;
    assign rd_start = ren_rise & ~rd_busy;

    assign mem_access_flag = wr_start | rd_start;

    assign offset = alu_result[OFFSET_BITS-1:0];

    assign st_word = mem_wtype[SIZE_WORD] & (offset == '0);
    assign st_half = mem_wtype[SIZE_HALF] & ~offset[0];
    assign st_byte = mem_wtype[SIZE_BYTE];

    assign wr_addr = alu_result;
    assign wr_data = mem_wdata << {offset, 3'b000}; // move data onto its byte lane.

    always_comb begin
        if (st_word) begin
            wr_strb = '1;
        end else if (st_half) begin
            wr_strb = STRB_WIDTH'(2'b11) << offset;
        end else if (st_byte) begin
            wr_strb = STRB_WIDTH'(1'b1) << offset;
        end else begin
            wr_strb = '0; // misaligned store, nothing written.
        end
    end

    assign rd_addr = alu_result;

    // with neither extension asked for, the raw word comes back.
    assign ld_raw       = (mem_zero_width == '0) && (mem_sext_width == '0);
    assign ld_size_next = ld_raw ? SIZE_BITS'(1 << SIZE_WORD) : mem_rtype;

    // lane info stays put until the next read start.
    always_ff @(posedge clk) begin
        if (rd_start) begin
            ld_offset <= offset;
            ld_size   <= ld_size_next;
            ld_sext   <= |mem_sext_width;
        end
    end

endmodule

`default_nettype wire

/* design/lsu_axi_write.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_axi_write
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_start,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  logic [DATA_WIDTH-1:0] wr_data,
    input  logic [STRB_WIDTH-1:0] wr_strb,
    input  logic                  awready,
    input  logic                  wready,
    input  logic                  bvalid,
    input  logic [RESP_BITS-1:0]  bresp,
    output logic                  awvalid,
    output logic [ADDR_WIDTH-1:0] awaddr,
    output logic [PROT_BITS-1:0]  awprot,
    output logic                  wvalid,
    output logic [DATA_WIDTH-1:0] wdata,
    output logic [STRB_WIDTH-1:0] wstrb,
    output logic                  bready,
    output logic                  wr_busy,
    output logic                  mem_wcomplete
);

    logic aw_hs;
    logic w_hs;
    logic b_hs;

    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;
    assign b_hs  = bvalid & bready;

    assign awprot = PROT_NONE;

    // payload is taken at the start and held for the whole transaction.
    always_ff @(posedge clk) begin
        if (wr_start) begin
            awaddr <= wr_addr;
            wdata  <= wr_data;
            wstrb  <= wr_strb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            wr_busy <= 1'b0;
        end else begin
            if (wr_start) begin
                awvalid <= 1'b1;
                wr_busy <= 1'b1;
            end else if (aw_hs) begin
                awvalid <= 1'b0;
            end

            if (aw_hs) begin
                wvalid <= 1'b1; // data phase follows the address.
            end else if (w_hs) begin
                wvalid <= 1'b0;
            end

            if (b_hs) begin
                wr_busy <= 1'b0;
            end
        end
    end

    // accept the response one cycle after it shows up.
    always_ff @(posedge clk) begin
        if (rst) begin
            bready <= 1'b0;
        end else if (b_hs) begin
            bready <= 1'b0;
        end else if (bvalid && wr_busy) begin
            bready <= 1'b1;
        end
    end

    // bresp is accepted as is, any code ends the write.
    assign mem_wcomplete = b_hs;

endmodule

`default_nettype wire

/* design/lsu_axi_read.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_axi_read
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rd_start,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    input  logic                  arready,
    input  logic                  rvalid,
    input  logic [DATA_WIDTH-1:0] rdata,
    input  logic [RESP_BITS-1:0]  rresp,
    output logic                  arvalid,
    output logic [ADDR_WIDTH-1:0] araddr,
    output logic [PROT_BITS-1:0]  arprot,
    output logic                  rready,
    output logic                  rd_busy,
    output logic                  rd_done,
    output logic [DATA_WIDTH-1:0] rd_word
);

    logic ar_hs;
    logic r_hs;
    logic ar_done; // address accepted, data still owed.

    assign ar_hs = arvalid & arready;
    assign r_hs  = rvalid & rready;

    assign arprot = PROT_NONE;

    always_ff @(posedge clk) begin
        if (rd_start) begin
            araddr <= rd_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
            ar_done <= 1'b0;
            rready  <= 1'b0;
        end else begin
            if (rd_start) begin
                arvalid <= 1'b1;
            end else if (ar_hs) begin
                arvalid <= 1'b0;
            end

            if (ar_hs) begin
                ar_done <= 1'b1;
            end else if (r_hs) begin
                ar_done <= 1'b0;
            end

            if (r_hs) begin
                rready <= 1'b0;
            end else if (rvalid && ar_done) begin
                rready <= 1'b1; // one cycle after rvalid is seen.
            end
        end
    end

    assign rd_busy = arvalid | ar_done;

    // rresp is not looked at, the word is passed on regardless.
    assign rd_done = r_hs;
    assign rd_word = rdata;

endmodule

`default_nettype wire

/* design/lsu_load_extend.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_extend
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd_done,
    input  logic [DATA_WIDTH-1:0]  rd_word,
    input  logic [OFFSET_BITS-1:0] ld_offset,
    input  logic [SIZE_BITS-1:0]   ld_size,
    input  logic                   ld_sext,
    output logic                   mem_rvalid,
    output logic [DATA_WIDTH-1:0]  mem_wreg
);

    logic [7:0]            lane_byte;
    logic [15:0]           lane_half;
    logic [DATA_WIDTH-1:0] load_value;

    assign lane_byte = rd_word[{ld_offset, 3'b000} +: 8];

    always_comb begin
        case (ld_offset)
            2'd0:    lane_half = rd_word[15:0];
            2'd2:    lane_half = rd_word[31:16];
            default: lane_half = 16'h0000; // odd offset.
        endcase
    end

    always_comb begin
        if (ld_size[SIZE_BYTE]) begin
            load_value = {{(DATA_WIDTH-8){ld_sext & lane_byte[7]}}, lane_byte};
        end else if (ld_size[SIZE_HALF]) begin
            load_value = {{(DATA_WIDTH-16){ld_sext & lane_half[15]}}, lane_half};
        end else begin
            load_value = rd_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_rvalid <= 1'b0;
        end else begin
            mem_rvalid <= rd_done;
        end
    end

    // result register, only loaded when a word arrives.
    always_ff @(posedge clk) begin
        if (rd_done) begin
            mem_wreg <= load_value;
        end
    end

endmodule

`default_nettype wire

/* design/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_valid,
    input  logic                  mem_ren,
    input  logic                  mem_wen,
    input  logic [ADDR_WIDTH-1:0] alu_result,
    input  logic [DATA_WIDTH-1:0] mem_wdata,
    input  logic [SIZE_BITS-1:0]  mem_wtype,
    input  logic [SIZE_BITS-1:0]  mem_rtype,
    input  logic [EXT_BITS-1:0]   mem_zero_width,
    input  logic [EXT_BITS-1:0]   mem_sext_width,
    output logic                  mem_access_flag,
    output logic                  mem_wcomplete,
    output logic                  mem_rvalid,
    output logic [DATA_WIDTH-1:0] mem_wreg,

    output logic                  awvalid,
    input  logic                  awready,
    output logic [ADDR_WIDTH-1:0] awaddr,
    output logic [PROT_BITS-1:0]  awprot,
    output logic                  wvalid,
    input  logic                  wready,
    output logic [DATA_WIDTH-1:0] wdata,
    output logic [STRB_WIDTH-1:0] wstrb,
    input  logic                  bvalid,
    output logic                  bready,
    input  logic [RESP_BITS-1:0]  bresp,
    output logic                  arvalid,
    input  logic                  arready,
    output logic [ADDR_WIDTH-1:0] araddr,
    output logic [PROT_BITS-1:0]  arprot,
    input  logic                  rvalid,
    output logic                  rready,
    input  logic [DATA_WIDTH-1:0] rdata,
    input  logic [RESP_BITS-1:0]  rresp
);

    logic                   wr_start;
    logic [ADDR_WIDTH-1:0]  wr_addr;
    logic [DATA_WIDTH-1:0]  wr_data;
    logic [STRB_WIDTH-1:0]  wr_strb;
    logic                   wr_busy;
    logic                   rd_start;
    logic [ADDR_WIDTH-1:0]  rd_addr;
    logic                   rd_busy;
    logic                   rd_done;
    logic [DATA_WIDTH-1:0]  rd_word;
    logic [OFFSET_BITS-1:0] ld_offset;
    logic [SIZE_BITS-1:0]   ld_size;
    logic                   ld_sext;

    lsu_request u_request (
        .clk, .rst, .mem_valid, .mem_ren, .mem_wen, .alu_result, .mem_wdata,
        .mem_wtype, .mem_rtype, .mem_zero_width, .mem_sext_width,
        .wr_busy, .rd_busy, .mem_access_flag,
        .wr_start, .wr_addr, .wr_data, .wr_strb,
        .rd_start, .rd_addr, .ld_offset, .ld_size, .ld_sext
    );

    lsu_axi_write u_axi_write (
        .clk, .rst, .wr_start, .wr_addr, .wr_data, .wr_strb,
        .awready, .wready, .bvalid, .bresp,
        .awvalid, .awaddr, .awprot, .wvalid, .wdata, .wstrb, .bready,
        .wr_busy, .mem_wcomplete
    );

    lsu_axi_read u_axi_read (
        .clk, .rst, .rd_start, .rd_addr, .arready, .rvalid, .rdata, .rresp,
        .arvalid, .araddr, .arprot, .rready, .rd_busy, .rd_done, .rd_word
    );

    // lane info from the request stage meets the word from the bus here.
    lsu_load_extend u_load_extend (
        .clk, .rst, .rd_done, .rd_word, .ld_offset, .ld_size, .ld_sext,
        .mem_rvalid, .mem_wreg
    );

endmodule

`default_nettype wire

/* tests/lsu_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_assert
    import lsu_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  awvalid,
    input logic                  awready,
    input logic [ADDR_WIDTH-1:0] awaddr,
    input logic                  wvalid,
    input logic                  bready,
    input logic                  arvalid,
    input logic                  arready,
    input logic [ADDR_WIDTH-1:0] araddr,
    input logic                  rvalid,
    input logic                  rready,
    input logic                  mem_rvalid,
    input logic                  mem_wcomplete,
    input logic                  mem_access_flag
);

    int assert_errors = 0;

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            $error("awvalid or awaddr changed before the AW handshake");
            assert_errors++;
        end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $error("arvalid or araddr changed before the AR handshake");
            assert_errors++;
        end

    // data phase only opens after the address went through.
    w_after_aw: assert property (@(posedge clk) disable iff (rst)
        $rose(wvalid) |-> $past(awvalid && awready))
        else begin
            $error("wvalid rose without an AW handshake");
            assert_errors++;
        end

    r_to_result: assert property (@(posedge clk) disable iff (rst)
        rvalid && rready |=> mem_rvalid)
        else begin
            $error("mem_rvalid missing one cycle after the R handshake");
            assert_errors++;
        end

    result_from_r: assert property (@(posedge clk) disable iff (rst)
        mem_rvalid |-> $past(rvalid && rready))
        else begin
            $error("mem_rvalid without an R handshake the cycle before");
            assert_errors++;
        end

    reset_quiet: assert property (@(posedge clk)
        rst |=> !(awvalid || wvalid || bready || arvalid || rready
                  || mem_rvalid || mem_wcomplete || mem_access_flag))
        else begin
            $error("an output is high during reset");
            assert_errors++;
        end

endmodule

bind lsu_top lsu_assert u_assert (.*);

`default_nettype wire

/* tests/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 72; // transactions over the whole run.
    localparam int WAIT_LIMIT   = 40;

    logic                  clk;
    logic                  rst;
    logic                  mem_valid;
    logic                  mem_ren;
    logic                  mem_wen;
    logic [ADDR_WIDTH-1:0] alu_result;
    logic [DATA_WIDTH-1:0] mem_wdata;
    logic [SIZE_BITS-1:0]  mem_wtype;
    logic [SIZE_BITS-1:0]  mem_rtype;
    logic [EXT_BITS-1:0]   mem_zero_width;
    logic [EXT_BITS-1:0]   mem_sext_width;
    logic                  mem_access_flag;
    logic                  mem_wcomplete;
    logic                  mem_rvalid;
    logic [DATA_WIDTH-1:0] mem_wreg;
    logic                  awvalid;
    logic                  awready;
    logic [ADDR_WIDTH-1:0] awaddr;
    logic [PROT_BITS-1:0]  awprot;
    logic                  wvalid;
    logic                  wready;
    logic [DATA_WIDTH-1:0] wdata;
    logic [STRB_WIDTH-1:0] wstrb;
    logic                  bvalid;
    logic                  bready;
    logic [RESP_BITS-1:0]  bresp;
    logic                  arvalid;
    logic                  arready;
    logic [ADDR_WIDTH-1:0] araddr;
    logic [PROT_BITS-1:0]  arprot;
    logic                  rvalid;
    logic                  rready;
    logic [DATA_WIDTH-1:0] rdata;
    logic [RESP_BITS-1:0]  rresp;

    logic [DATA_WIDTH-1:0] mem [256];
    logic [31:0]           lfsr;
    logic [3:0]            rnd;
    logic [7:0]            aw_idx;
    logic [7:0]            ar_idx;
    logic [3:0]            b_wait;
    logic [3:0]            r_wait;
    logic                  b_pend;
    logic                  r_pend;
    int                    value_errors;
    int                    pulse_errors;
    int                    flag_count;
    int                    wdone_count;
    int                    rdone_count;

    lsu_top uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // right-shifting Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_random_bits(input int n, output logic [3:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr   = lfsr_step(lfsr);
            val[i] = lfsr[0];
        end
    endtask

    // memory slave, random readiness and response delays of 0 to 3 cycles.
    always @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            b_pend = 1'b0;
            r_pend = 1'b0;
        end else begin
            take_random_bits(3, rnd);
            awready <= rnd[0];
            wready  <= rnd[1];
            arready <= rnd[2];
            if (awvalid && awready) begin
                aw_idx = awaddr[9:2];
                check_prot(awprot, '0, "awprot on the AW handshake");
            end
            if (wvalid && wready) begin
                for (int i = 0; i < STRB_WIDTH; i++) begin
                    if (wstrb[i]) begin
                        mem[aw_idx][i*8 +: 8] = wdata[i*8 +: 8];
                    end
                end
                take_random_bits(2, b_wait);
                b_pend = 1'b1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (b_pend && b_wait == 0) begin
                bvalid <= 1'b1;
                bresp  <= RESP_OKAY;
                b_pend = 1'b0;
            end else if (b_pend) begin
                b_wait = b_wait - 1;
            end
            if (arvalid && arready) begin
                ar_idx = araddr[9:2];
                check_prot(arprot, '0, "arprot on the AR handshake");
                take_random_bits(2, r_wait);
                r_pend = 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (r_pend && r_wait == 0) begin
                rvalid <= 1'b1;
                rdata  <= mem[ar_idx];
                rresp  <= RESP_OKAY;
                r_pend = 1'b0;
            end else if (r_pend) begin
                r_wait = r_wait - 1;
            end
        end
    end

    // pulse counters, sampled mid-cycle.
    always @(negedge clk) begin
        if (!rst) begin
            flag_count  += int'(mem_access_flag);
            wdone_count += int'(mem_wcomplete);
            rdone_count += int'(mem_rvalid);
        end
    end

    function automatic logic [DATA_WIDTH-1:0] expected_store(input logic [DATA_WIDTH-1:0] old,
        input logic [DATA_WIDTH-1:0] data, input int size, input int off);
        logic [DATA_WIDTH-1:0] w;
        w = old;
        if (size == SIZE_WORD && off == 0) begin
            w = data;
        end else if (size == SIZE_HALF && off % 2 == 0) begin
            w[off*8 +: 8]     = data[7:0];
            w[off*8 + 8 +: 8] = data[15:8];
        end else if (size == SIZE_BYTE) begin
            w[off*8 +: 8] = data[7:0];
        end
        return w; // misaligned halfword or word keeps the old word.
    endfunction

    function automatic logic [DATA_WIDTH-1:0] expected_load(input logic [DATA_WIDTH-1:0] word,
        input int size, input logic sext, input int off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[off*8 +: 8];
        h = (off == 0) ? word[15:0] : (off == 2) ? word[31:16] : 16'h0000;
        if (size == SIZE_BYTE) begin
            return {{24{sext & b[7]}}, b};
        end else if (size == SIZE_HALF) begin
            return {{16{sext & h[15]}}, h};
        end
        return word;
    endfunction

    task automatic check_load(input logic [DATA_WIDTH-1:0] got, exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t: %s, mem_wreg %h, expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_store(input logic [DATA_WIDTH-1:0] got, exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t: %s, memory word %h, expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_prot(input logic [PROT_BITS-1:0] got, exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input logic got, exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_count(input int got, exp, input string what);
        if (got != exp) begin
            $display("Fail %0t: %0d %s, expected %0d", $time, got, what, exp);
            value_errors++;
        end
    endtask

    task automatic wait_wcomplete(input logic [ADDR_WIDTH-1:0] addr);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!mem_wcomplete && n < WAIT_LIMIT);
        if (!mem_wcomplete) begin
            $display("no mem_wcomplete pulse after the store to %h", addr);
            pulse_errors++;
        end
    endtask

    task automatic wait_rvalid(input logic [ADDR_WIDTH-1:0] addr,
        output logic [DATA_WIDTH-1:0] result);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!mem_rvalid && n < WAIT_LIMIT);
        result = mem_wreg;
        if (!mem_rvalid) begin
            $display("no mem_rvalid pulse after the load from %h", addr);
            pulse_errors++;
        end
    endtask

    task automatic issue_store(input logic [ADDR_WIDTH-1:0] addr,
        input logic [DATA_WIDTH-1:0] data, input int size, input int hold);
        @(posedge clk);
        mem_valid  <= 1'b1;
        mem_wen    <= 1'b1;
        alu_result <= addr;
        mem_wdata  <= data;
        mem_wtype  <= SIZE_BITS'(1 << size);
        wait_wcomplete(addr);
        repeat (hold) @(posedge clk);
        mem_wen <= 1'b0;
    endtask

    task automatic issue_load(input logic [ADDR_WIDTH-1:0] addr, input int size,
        input logic sext, input int hold, output logic [DATA_WIDTH-1:0] result);
        logic [EXT_BITS-1:0] ext;
        ext = (size == SIZE_WORD) ? '0 : EXT_BITS'(1 << size); // both zero asks for the raw word.
        @(posedge clk);
        mem_valid      <= 1'b1;
        mem_ren        <= 1'b1;
        alu_result     <= addr;
        mem_rtype      <= SIZE_BITS'(1 << size);
        mem_sext_width <= sext ? ext : '0;
        mem_zero_width <= sext ? '0 : ext;
        wait_rvalid(addr, result);
        repeat (hold) @(posedge clk);
        mem_ren <= 1'b0;
    endtask

    task automatic reset_levels();
        @(posedge clk);
        check_flag(awvalid, 1'b0, "awvalid after reset");
        check_flag(wvalid, 1'b0, "wvalid after reset");
        check_flag(bready, 1'b0, "bready after reset");
        check_flag(arvalid, 1'b0, "arvalid after reset");
        check_flag(rready, 1'b0, "rready after reset");
        check_flag(mem_wcomplete, 1'b0, "mem_wcomplete after reset");
        check_flag(mem_rvalid, 1'b0, "mem_rvalid after reset");
        check_flag(mem_access_flag, 1'b0, "mem_access_flag after reset");
    endtask

    task automatic store_lanes();
        logic [7:0]            idx;
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_WIDTH-1:0] old;
        for (int size = 0; size < 3; size++) begin
            for (int off = 0; off < 4; off++) begin
                idx  = 8'h10 + 8'(size * 4 + off);
                data = 32'hc3b2_a190 ^ {4{8'(size * 4 + off)}};
                old  = mem[idx];
                issue_store({22'h0, idx, 2'(off)}, data, size, 0);
                check_store(mem[idx], expected_store(old, data, size, off),
                    $sformatf("store size %0d offset %0d", size, off));
            end
        end
    endtask

    task automatic load_lanes();
        logic [DATA_WIDTH-1:0] pats [2];
        logic [DATA_WIDTH-1:0] got;
        logic [7:0]            idx;
        pats[0] = 32'h9483_f281; // bit 7 and bit 15 set in every lane.
        pats[1] = 32'h6a15_7c2e;
        for (int p = 0; p < 2; p++) begin
            for (int off = 0; off < 4; off++) begin
                for (int kind = 0; kind < 5; kind++) begin
                    idx      = 8'h40 + 8'(off);
                    mem[idx] = pats[p];
                    issue_load({22'h0, idx, 2'(off)}, kind / 2, kind % 2 == 0, 0, got);
                    check_load(got, expected_load(pats[p], kind / 2, kind % 2 == 0, off),
                        $sformatf("load kind %0d offset %0d word %h", kind, off, pats[p]));
                end
            end
        end
    endtask

    task automatic random_traffic();
        logic [7:0]            idx;
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_WIDTH-1:0] model;
        logic [DATA_WIDTH-1:0] got;
        int                    size;
        int                    off;
        int                    w0;
        int                    r0;
        for (int i = 0; i < 8; i++) begin
            idx   = 8'h80 + 8'(i);
            data  = 32'h1357_9bdf ^ (i * 32'h0f1e_2d3c);
            size  = i[0] ? SIZE_HALF : SIZE_WORD;
            off   = i[0] ? 2 : 0;
            model = expected_store(mem[idx], data, size, off);
            w0    = wdone_count;
            r0    = rdone_count;
            issue_store({22'h0, idx, 2'(off)}, data, size, 0);
            issue_load({22'h0, idx, 2'(off)}, size, 1'b1, 0, got);
            check_load(got, expected_load(model, size, 1'b1, off), "load after store");
            check_count(wdone_count - w0, 1, "write completions per store");
            check_count(rdone_count - r0, 1, "load results per load");
        end
    endtask

    task automatic held_enables();
        logic [DATA_WIDTH-1:0] got;
        int                    f0;
        int                    w0;
        int                    r0;
        f0 = flag_count;
        w0 = wdone_count;
        r0 = rdone_count;
        issue_store(32'h0000_0300, 32'hdead_beef, SIZE_WORD, 6);
        issue_load(32'h0000_0300, SIZE_WORD, 1'b0, 6, got);
        check_load(got, 32'hdead_beef, "load with a held enable");
        check_count(flag_count - f0, 2, "access flags with held enables");
        check_count(wdone_count - w0, 1, "write completions with a held enable");
        check_count(rdone_count - r0, 1, "load results with a held enable");
    endtask

    task automatic dropped_read_edge();
        logic [DATA_WIDTH-1:0] got;
        int                    f0;
        int                    r0;
        f0 = flag_count;
        r0 = rdone_count;
        @(posedge clk);
        mem_valid      <= 1'b1;
        alu_result     <= 32'h0000_0340;
        mem_rtype      <= SIZE_BITS'(1 << SIZE_WORD);
        mem_sext_width <= '0;
        mem_zero_width <= '0;
        mem_ren        <= 1'b1;
        @(posedge clk);
        mem_ren <= 1'b0;
        @(posedge clk);
        mem_ren <= 1'b1; // second edge lands while the first read is still out.
        wait_rvalid(32'h0000_0340, got);
        repeat (12) @(posedge clk);
        mem_ren <= 1'b0;
        check_load(got, mem[8'hd0], "read with a dropped second edge");
        check_count(rdone_count - r0, 1, "load results for two close read edges");
        check_count(flag_count - f0, 1, "access flags for two close read edges");
    endtask

    initial begin
        #((NUM_TESTS * 40 + RESET_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        mem_valid      = 1'b0;
        mem_ren        = 1'b0;
        mem_wen        = 1'b0;
        alu_result     = '0;
        mem_wdata      = '0;
        mem_wtype      = '0;
        mem_rtype      = '0;
        mem_zero_width = '0;
        mem_sext_width = '0;
        awready        = 1'b0;
        wready         = 1'b0;
        bvalid         = 1'b0;
        bresp          = RESP_OKAY;
        arready        = 1'b0;
        rvalid         = 1'b0;
        rdata          = '0;
        rresp          = RESP_OKAY;
        lfsr           = 32'h5e36_fa69;
        value_errors   = 0;
        pulse_errors   = 0;
        flag_count     = 0;
        wdone_count    = 0;
        rdone_count    = 0;
        for (int k = 0; k < 256; k++) begin
            mem[k] = {8'(k), ~8'(k), 8'(k) ^ 8'h3c, 8'(k) + 8'h71};
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        reset_levels();
        store_lanes();
        load_lanes();
        random_traffic();
        held_enables();
        dropped_read_edge();
        repeat (4) @(posedge clk);
        $display("errors: %0d wrong values, %0d missing pulses, %0d assertion failures",
            value_errors, pulse_errors, uut.u_assert.assert_errors);
        if (value_errors == 0 && pulse_errors == 0 && uut.u_assert.assert_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
design/lsu_pkg.sv
design/lsu_request.sv
design/lsu_axi_write.sv
design/lsu_axi_read.sv
design/lsu_load_extend.sv
design/lsu_top.sv
tests/lsu_assert.sv
tests/lsu_tb.sv
